// ==== hdl/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// Direct-mapped cache, 16 sets of 4 words
`define DCACHE_INDEX_W 4
`define DCACHE_OFFSET_W 2
`define DCACHE_TAG_W (`LSU_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W - 2)

// Word address bits decoded by main memory
`define MEM_ADDR_W 10

// Cycles from accepted request to done pulse, at least 2
`define MEM_LAT 3

`endif

// ==== hdl/lsu_pkg.sv ====
`include "lsu_defs.svh"

package lsu_pkg;

    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_INDEX_W-1:0]  index;
        logic [`DCACHE_OFFSET_W-1:0] word_off;
        logic [1:0]                  byte_off;
    } lsu_addr_fields_t;

    // Same word seen raw by the uncache path, split by the cache
    typedef union packed {
        logic [`LSU_ADDR_W-1:0] raw;
        lsu_addr_fields_t       f;
    } lsu_addr_u;

    typedef struct packed {
        lsu_addr_u                addr;
        logic [`LSU_DATA_W-1:0]   wdata;
        logic [`LSU_DATA_W/8-1:0] wstrb;
        logic                     uncached;
    } cpu_req_t;

    // Mode 1 checks the tag, every other mode drops the line
    typedef struct packed {
        logic [1:0] mode;
        lsu_addr_u  addr;
    } cacop_req_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-3:0]   addr;
        logic [`LSU_DATA_W-1:0]   wdata;
        logic [`LSU_DATA_W/8-1:0] wstrb;
        logic                     we;
    } mem_req_t;

endpackage

// ==== hdl/lsu.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   cpu_valid,
    input  lsu_pkg::cpu_req_t      cpu_req,
    output logic                   cpu_ready,
    output logic [`LSU_DATA_W-1:0] cpu_rdata,
    output logic                   cpu_data_valid,

    input  logic                   cpu_flush,
    input  logic                   cpu_store_commit,

    input  logic                   cpu_cacop,
    input  lsu_pkg::cacop_req_t    cacop_req,

    output logic                   dcache_valid,
    output lsu_pkg::cpu_req_t      dcache_req,
    input  logic [`LSU_DATA_W-1:0] dcache_rdata,
    input  logic                   dcache_ready,

    output logic                   dcache_cacop,
    output lsu_pkg::cacop_req_t    dcache_cacop_req,

    output logic                   unc_valid,
    output lsu_pkg::cpu_req_t      unc_req,
    input  logic                   unc_accept,
    input  logic                   unc_data_ok,
    input  logic [`LSU_DATA_W-1:0] unc_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_refill_wait,
        st_store_commit_wait,
        st_store_send,
        st_store_wait,
        st_unc_send,
        st_unc_wait,
        st_cacop_wait
    } state_t;

    state_t              state;
    state_t              next_state;
    lsu_pkg::cpu_req_t   p1_req;
    lsu_pkg::cacop_req_t p1_cacop;
    logic                accept;
    logic                cop_accept;
    logic                cpu_store;
    logic                p1_store;

    assign cpu_ready  = state == st_idle;
    assign accept     = cpu_valid & cpu_ready;
    // A memory request wins if both arrive together
    assign cop_accept = cpu_cacop & cpu_ready & ~cpu_valid;
    assign cpu_store  = |cpu_req.wstrb;
    assign p1_store   = |p1_req.wstrb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    if (cpu_store) begin
                        next_state = st_store_commit_wait;
                    end else if (cpu_req.uncached) begin
                        next_state = st_unc_send;
                    end else begin
                        next_state = st_refill_wait;
                    end
                end else if (cop_accept) begin
                    next_state = st_cacop_wait;
                end
            end
            st_refill_wait: begin
                if (dcache_ready) next_state = st_idle;
            end
            st_store_commit_wait: begin
                if (cpu_store_commit) begin
                    next_state = p1_req.uncached ? st_unc_send : st_store_send;
                end else if (cpu_flush) begin
                    next_state = st_idle;
                end
            end
            st_store_send: begin
                next_state = dcache_ready ? st_idle : st_store_wait;
            end
            st_store_wait: begin
                if (dcache_ready) next_state = st_idle;
            end
            st_unc_send: begin
                if (unc_accept) next_state = st_unc_wait;
            end
            st_unc_wait: begin
                if (unc_data_ok) next_state = st_idle;
            end
            st_cacop_wait: begin
                if (dcache_ready) next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    // Request stage
    always_ff @(posedge clk) begin
        if (accept) begin
            p1_req <= cpu_req;
        end
        if (cop_accept) begin
            p1_cacop <= cacop_req;
        end
    end

    // Cached loads bypass the stage so a hit answers next cycle
    always_comb begin
        dcache_valid = 1'b0;
        case (state)
            st_idle:        dcache_valid = accept & ~cpu_store & ~cpu_req.uncached;
            st_refill_wait: dcache_valid = ~dcache_ready;
            st_store_send:  dcache_valid = 1'b1;
            st_store_wait:  dcache_valid = ~dcache_ready;
            default:        dcache_valid = 1'b0;
        endcase
    end

    assign dcache_req       = (state == st_idle) ? cpu_req : p1_req;
    assign dcache_cacop     = state == st_cacop_wait;
    assign dcache_cacop_req = p1_cacop;

    assign unc_valid = state == st_unc_send;
    assign unc_req   = p1_req;

    always_comb begin
        cpu_data_valid = 1'b0;
        cpu_rdata      = dcache_rdata;
        case (state)
            st_refill_wait: begin
                cpu_data_valid = dcache_ready;
            end
            st_unc_wait: begin
                // Stores finish silently
                cpu_data_valid = unc_data_ok & ~p1_store;
                cpu_rdata      = unc_rdata;
            end
            default: begin
                cpu_data_valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/dcache.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module dcache (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  lsu_pkg::cpu_req_t      req,
    output logic [`LSU_DATA_W-1:0] rdata,
    output logic                   ready,
    input  logic                   cacop,
    input  lsu_pkg::cacop_req_t    cacop_req,
    output logic                   mem_valid,
    output lsu_pkg::mem_req_t      mem_req,
    input  logic                   mem_done,
    input  logic [`LSU_DATA_W-1:0] mem_rdata
);

    localparam int SETS  = 1 << `DCACHE_INDEX_W;
    localparam int WORDS = SETS << `DCACHE_OFFSET_W;

    typedef enum logic [2:0] {st_idle, st_lookup, st_refill, st_write, st_inv} state_t;

    state_t                       state;
    lsu_pkg::cpu_req_t            req_r;
    lsu_pkg::cacop_req_t          cop_r;
    logic [`DCACHE_OFFSET_W-1:0]  rcnt;
    logic [SETS-1:0]              line_valid;
    logic [`DCACHE_TAG_W-1:0]     tag_mem [SETS];
    logic [`LSU_DATA_W-1:0]       data_mem [WORDS];
    logic [`DCACHE_INDEX_W-1:0]   idx;
    logic [`DCACHE_INDEX_W-1:0]   cop_idx;
    logic                         hit;
    logic                         is_store;
    logic                         inv_line;

    assign idx      = req_r.addr.f.index;
    assign cop_idx  = cop_r.addr.f.index;
    assign hit      = line_valid[idx] & (tag_mem[idx] == req_r.addr.f.tag);
    assign is_store = |req_r.wstrb;
    assign inv_line = (cop_r.mode != 2'd1) | (tag_mem[cop_idx] == cop_r.addr.f.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            line_valid <= '0;
            rcnt       <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (cacop) state <= st_inv;
                    else if (valid) state <= st_lookup;
                end
                st_lookup: begin
                    if (is_store) begin
                        state <= st_write;
                    end else if (!hit) begin
                        rcnt  <= '0;
                        state <= st_refill;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_refill: begin
                    if (mem_done) begin
                        rcnt <= rcnt + 1'b1;
                        // Last word in, look up again to answer
                        if (&rcnt) begin
                            line_valid[idx] <= 1'b1;
                            state           <= st_lookup;
                        end
                    end
                end
                st_write: begin
                    if (mem_done) state <= st_idle;
                end
                st_inv: begin
                    if (inv_line) line_valid[cop_idx] <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && !cacop && valid) req_r <= req;
        if (state == st_idle && cacop) cop_r <= cacop_req;
        // Store hit merges bytes, a miss leaves the line alone
        if (state == st_lookup && is_store && hit) begin
            for (int b = 0; b < `LSU_DATA_W / 8; b++) begin
                if (req_r.wstrb[b]) begin
                    data_mem[{idx, req_r.addr.f.word_off}][8*b +: 8] <= req_r.wdata[8*b +: 8];
                end
            end
        end
        if (state == st_refill && mem_done) begin
            data_mem[{idx, rcnt}] <= mem_rdata;
            if (&rcnt) tag_mem[idx] <= req_r.addr.f.tag;
        end
    end

    assign rdata = data_mem[{idx, req_r.addr.f.word_off}];
    assign ready = (state == st_lookup && !is_store && hit)
                 | (state == st_write && mem_done)
                 | (state == st_inv);

    assign mem_valid     = (state == st_refill) | (state == st_write);
    assign mem_req.addr  = (state == st_write) ? req_r.addr.raw[`LSU_ADDR_W-1:2]
                                               : {req_r.addr.f.tag, idx, rcnt};
    assign mem_req.wdata = req_r.wdata;
    assign mem_req.wstrb = (state == st_write) ? req_r.wstrb : '0;
    assign mem_req.we    = state == st_write;

endmodule

// ==== hdl/uncache_channel.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module uncache_channel (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  lsu_pkg::cpu_req_t      req,
    output logic                   accept,
    output logic                   data_ok,
    output logic [`LSU_DATA_W-1:0] rdata,
    output logic                   mem_valid,
    output lsu_pkg::mem_req_t      mem_req,
    input  logic                   mem_done,
    input  logic [`LSU_DATA_W-1:0] mem_rdata
);

    logic              busy;
    lsu_pkg::cpu_req_t req_r;

    // One access in flight at a time
    assign accept = valid & ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= busy & mem_done;
            if (accept) begin
                busy <= 1'b1;
            end else if (mem_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_r <= req;
        if (busy && mem_done) rdata <= mem_rdata;
    end

    assign mem_valid     = busy;
    assign mem_req.addr  = req_r.addr.raw[`LSU_ADDR_W-1:2];
    assign mem_req.wdata = req_r.wdata;
    assign mem_req.wstrb = req_r.wstrb;
    assign mem_req.we    = |req_r.wstrb;

endmodule

// ==== hdl/main_mem.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module main_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   c_valid,
    input  lsu_pkg::mem_req_t      c_req,
    output logic                   c_done,
    output logic [`LSU_DATA_W-1:0] c_rdata,
    input  logic                   u_valid,
    input  lsu_pkg::mem_req_t      u_req,
    output logic                   u_done,
    output logic [`LSU_DATA_W-1:0] u_rdata
);

    localparam int DEPTH = 1 << `MEM_ADDR_W;
    localparam int CNT_W = $clog2(`MEM_LAT) + 1;

    logic [`LSU_DATA_W-1:0] mem [DEPTH];
    logic                   busy;
    logic                   sel_u;
    logic [CNT_W-1:0]       cnt;
    lsu_pkg::mem_req_t      cur;
    logic [`LSU_DATA_W-1:0] rd_q;
    logic                   can_take;
    logic                   take_c;
    logic                   take_u;
    logic                   fire;
    logic [`MEM_ADDR_W-1:0] waddr;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'(i) * 32'h0101_0101;
        end
    end

    // Skip the done cycle, the requester still shows the old request
    assign can_take = ~busy & ~c_done & ~u_done;
    assign take_c   = can_take & c_valid;
    assign take_u   = can_take & ~c_valid & u_valid;
    assign fire     = busy & (cnt == CNT_W'(`MEM_LAT - 1));
    assign waddr    = cur.addr[`MEM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            sel_u  <= 1'b0;
            cnt    <= '0;
            c_done <= 1'b0;
            u_done <= 1'b0;
        end else begin
            c_done <= fire & ~sel_u;
            u_done <= fire & sel_u;
            if (take_c || take_u) begin
                busy  <= 1'b1;
                sel_u <= take_u;
                cnt   <= CNT_W'(1);
            end else if (fire) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_c) cur <= c_req;
        else if (take_u) cur <= u_req;
        if (fire) begin
            rd_q <= mem[waddr];
            if (cur.we) begin
                for (int b = 0; b < `LSU_DATA_W / 8; b++) begin
                    if (cur.wstrb[b]) mem[waddr][8*b +: 8] <= cur.wdata[8*b +: 8];
                end
            end
        end
    end

    assign c_rdata = rd_q;
    assign u_rdata = rd_q;

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_valid,
    input  lsu_pkg::cpu_req_t      cpu_req,
    output logic                   cpu_ready,
    output logic [`LSU_DATA_W-1:0] cpu_rdata,
    output logic                   cpu_data_valid,
    input  logic                   cpu_flush,
    input  logic                   cpu_store_commit,
    input  logic                   cpu_cacop,
    input  lsu_pkg::cacop_req_t    cacop_req
);

    logic                   dcache_valid;
    logic                   dcache_ready;
    logic                   dcache_cacop;
    lsu_pkg::cpu_req_t      dcache_req;
    lsu_pkg::cacop_req_t    dcache_cacop_req;
    logic [`LSU_DATA_W-1:0] dcache_rdata;
    logic                   unc_valid;
    logic                   unc_accept;
    logic                   unc_data_ok;
    lsu_pkg::cpu_req_t      unc_req;
    logic [`LSU_DATA_W-1:0] unc_rdata;

    // Memory side of cache and uncache ports
    logic                   c_valid;
    logic                   c_done;
    lsu_pkg::mem_req_t      c_req;
    logic [`LSU_DATA_W-1:0] c_rdata;
    logic                   u_valid;
    logic                   u_done;
    lsu_pkg::mem_req_t      u_req;
    logic [`LSU_DATA_W-1:0] u_rdata;

    lsu u_lsu (.*);

    dcache u_dcache (
        .clk(clk), .rst(rst),
        .valid(dcache_valid), .req(dcache_req), .rdata(dcache_rdata), .ready(dcache_ready),
        .cacop(dcache_cacop), .cacop_req(dcache_cacop_req),
        .mem_valid(c_valid), .mem_req(c_req), .mem_done(c_done), .mem_rdata(c_rdata)
    );

    uncache_channel u_uncache (
        .clk(clk), .rst(rst),
        .valid(unc_valid), .req(unc_req), .accept(unc_accept),
        .data_ok(unc_data_ok), .rdata(unc_rdata),
        .mem_valid(u_valid), .mem_req(u_req), .mem_done(u_done), .mem_rdata(u_rdata)
    );

    main_mem u_mem (.*);

endmodule

// ==== verification/lsu_properties.sv ====
`timescale 1ns/1ps

module lsu_properties (
    input logic clk,
    input logic rst,
    input logic cpu_ready,
    input logic cpu_data_valid,
    input logic dcache_valid,
    input logic dcache_cacop,
    input logic unc_valid
);

    int fail_count = 0;

    // Only one downstream path active at a time
    cache_unc_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dcache_valid && unc_valid))
        else begin
            fail_count++;
            $error("dcache_valid and unc_valid high in the same cycle");
        end

    cacop_req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dcache_cacop && dcache_valid))
        else begin
            fail_count++;
            $error("dcache_cacop and dcache_valid high in the same cycle");
        end

    no_data_while_ready: assert property (@(posedge clk) disable iff (rst)
        !(cpu_data_valid && cpu_ready))
        else begin
            fail_count++;
            $error("cpu_data_valid high in a cycle that can accept a new request");
        end

endmodule

bind lsu lsu_properties props (.*);

// ==== verification/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int N_OPS       = 400;
    localparam int OP_CYCLES   = 60;
    localparam int WATCHDOG_NS = N_OPS * OP_CYCLES * CLK_PERIOD;

    logic                   clk;
    logic                   rst;
    logic                   cpu_valid;
    lsu_pkg::cpu_req_t      cpu_req;
    logic                   cpu_ready;
    logic [`LSU_DATA_W-1:0] cpu_rdata;
    logic                   cpu_data_valid;
    logic                   cpu_flush;
    logic                   cpu_store_commit;
    logic                   cpu_cacop;
    lsu_pkg::cacop_req_t    cacop_req;

    // Reference copy of memory and of what the cache should hold
    logic [31:0]              mem_model [1024];
    logic [31:0]              line_data [64];
    logic [`DCACHE_TAG_W-1:0] line_tag [16];
    logic                     line_valid [16];
    logic [31:0]              lcg_state;

    lsu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  wstrb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic line_hit(input logic [31:0] addr);
        return line_valid[addr[7:4]] && (line_tag[addr[7:4]] == addr[31:8]);
    endfunction

    // Miss refills all four words of the line
    function automatic logic [31:0] predict_cached_load(input logic [31:0] addr);
        logic [3:0] idx;
        idx = addr[7:4];
        if (!line_hit(addr)) begin
            for (int k = 0; k < 4; k++) begin
                line_data[{idx, 2'(k)}] = mem_model[{addr[11:4], 2'(k)}];
            end
            line_tag[idx]   = addr[31:8];
            line_valid[idx] = 1'b1;
        end
        return line_data[{idx, addr[3:2]}];
    endfunction

    // Write-through with the line changed only on a cached hit
    function automatic void apply_store(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic [3:0] wstrb, input logic uncached);
        if (!uncached && line_hit(addr)) begin
            line_data[addr[7:2]] = merge_bytes(line_data[addr[7:2]], wdata, wstrb);
        end
        mem_model[addr[11:2]] = merge_bytes(mem_model[addr[11:2]], wdata, wstrb);
    endfunction

    function automatic void apply_cacop(input logic [1:0] mode, input logic [31:0] addr);
        if (mode != 2'd1 || line_tag[addr[7:4]] == addr[31:8]) begin
            line_valid[addr[7:4]] = 1'b0;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %08h actual %08h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic send_request(input lsu_pkg::cpu_req_t req);
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_req   <= req;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
        cpu_valid <= 1'b0;
    endtask

    // No read data may appear while a store or cacop drains
    task automatic wait_idle(input string name);
        @(negedge clk);
        while (!cpu_ready) begin
            check_value(name, 32'd0, 32'(cpu_data_valid));
            @(negedge clk);
        end
    endtask

    task automatic load_op(input logic [31:0] addr, input logic uncached);
        lsu_pkg::cpu_req_t req;
        logic [31:0]       expected;
        logic              hit;
        int                cycles;
        req          = '0;
        req.addr.raw = addr;
        req.uncached = uncached;
        hit          = !uncached && line_hit(addr);
        if (uncached) begin
            expected = mem_model[addr[11:2]];
        end else begin
            expected = predict_cached_load(addr);
        end
        send_request(req);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            // Busy until the load data returns
            check_value("load ready", 32'd0, 32'(cpu_ready));
        end while (!cpu_data_valid);
        if (uncached) begin
            check_value("uncached load", expected, cpu_rdata);
        end else begin
            check_value("cached load", expected, cpu_rdata);
            check_value("hit latency", 32'(hit), 32'(cycles == 1));
        end
    endtask

    task automatic store_op(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic uncached,
                            input logic flush, input int delay);
        lsu_pkg::cpu_req_t req;
        req          = '0;
        req.addr.raw = addr;
        req.wdata    = wdata;
        req.wstrb    = wstrb;
        req.uncached = uncached;
        send_request(req);
        repeat (delay) @(posedge clk);
        if (flush) begin
            cpu_flush <= 1'b1;
        end else begin
            cpu_store_commit <= 1'b1;
        end
        @(posedge clk);
        cpu_flush        <= 1'b0;
        cpu_store_commit <= 1'b0;
        if (!flush) apply_store(addr, wdata, wstrb, uncached);
        wait_idle("store data_valid");
    endtask

    task automatic cacop_op(input logic [1:0] mode, input logic [31:0] addr);
        lsu_pkg::cacop_req_t op;
        op          = '0;
        op.mode     = mode;
        op.addr.raw = addr;
        @(posedge clk);
        cpu_cacop <= 1'b1;
        cacop_req <= op;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
        cpu_cacop <= 1'b0;
        apply_cacop(mode, addr);
        wait_idle("cacop data_valid");
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        lcg_state        = 32'd10;
        rst              = 1'b1;
        cpu_valid        = 1'b0;
        cpu_req          = '0;
        cpu_flush        = 1'b0;
        cpu_store_commit = 1'b0;
        cpu_cacop        = 1'b0;
        cacop_req        = '0;
        for (int i = 0; i < 1024; i++) begin
            mem_model[i] = 32'(i) * 32'h0101_0101;
        end
        for (int i = 0; i < 16; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < N_OPS; n++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            r3 = lcg_next();
            r4 = lcg_next();
            // Half the time stay in 1 KB so lines get reused
            addr  = r2[31] ? {22'd0, r2[23:16], 2'b00} : {20'd0, r2[25:16], 2'b00};
            wstrb = (r2[30:27] == 4'd0) ? 4'hf : r2[30:27];
            if (r1[31:28] < 4'd7) begin
                load_op(addr, r1[27:26] == 2'd0);
            end else if (r1[31:28] < 4'd13) begin
                store_op(addr, {r3[31:16], r4[31:16]}, wstrb, r1[27:26] == 2'd0,
                         r1[25:24] == 2'd0, int'(r1[21:20]));
            end else begin
                cacop_op(r1[23:22], addr);
            end
        end

        repeat (4) @(posedge clk);
        if (uut.u_lsu.props.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "%0d assertion failures in lsu", uut.u_lsu.props.fail_count);
        end
    end

endmodule

// ==== lsu_top.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/dcache.sv
hdl/uncache_channel.sv
hdl/main_mem.sv
hdl/lsu_top.sv
verification/lsu_properties.sv
verification/lsu_tb.sv

// ==== Makefile ====
TOP = lsu_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f lsu_top.f -Mdir obj_dir -o $(TOP)

run: compile
	-./obj_dir/$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
